//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tbDcache
FLIST = list.f
OBJDIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- dcacheConfig.sv
// ------------------
// Cache config block
// ------------------
module dcacheConfig (
    input logic clk,
    input logic rstN,
    input logic cfgValid,
    input dcachePkg::cfgOpT cfgOp,
    output logic cfgReady,
    maintIf.cfg maint
);

    logic enableQ;
    logic maintValidQ;
    dcachePkg::maintOpT maintOpQ;
    logic cfgReadyQ;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            enableQ <= 1'b0;
            maintValidQ <= 1'b0;
            maintOpQ <= dcachePkg::MAINT_INVALIDATE;
            cfgReadyQ <= 1'b0;
        end else begin
            // Ack is a single pulse
            cfgReadyQ <= 1'b0;
            if (maintValidQ) begin
                // Sweep running, wait for its end
                if (maint.maintReady) begin
                    maintValidQ <= 1'b0;
                    cfgReadyQ <= 1'b1;
                end
            end else if (cfgValid && !cfgReadyQ) begin
                case (cfgOp)
                    dcachePkg::CFG_ENABLE: begin
                        enableQ <= 1'b1;
                        cfgReadyQ <= 1'b1;
                    end
                    dcachePkg::CFG_DISABLE: begin
                        enableQ <= 1'b0;
                        cfgReadyQ <= 1'b1;
                    end
                    dcachePkg::CFG_INVALIDATE: begin
                        maintValidQ <= 1'b1;
                        maintOpQ <= dcachePkg::MAINT_INVALIDATE;
                    end
                    dcachePkg::CFG_CLEAN: begin
                        maintValidQ <= 1'b1;
                        maintOpQ <= dcachePkg::MAINT_CLEAN;
                    end
                endcase
            end
        end
    end

    assign cfgReady = cfgReadyQ;
    assign maint.maintValid = maintValidQ;
    assign maint.maintOp = maintOpQ;
    assign maint.cacheEnable = enableQ;

    // Command held steady until the controller finishes the sweep
    maintHoldA: assert property (@(posedge clk) disable iff (!rstN)
        maintValidQ && !maint.maintReady |=> maintValidQ && $stable(maintOpQ));

endmodule

//--- dcacheController.sv
// ------------------
// Cache controller
// ------------------
module dcacheController (
    input logic clk,
    input logic rstN,
    // Processor side
    input logic cpuValid,
    input logic cpuWrite,
    input logic [31:0] cpuAddr,
    input logic [31:0] cpuWData,
    input logic [3:0] cpuByteMask,
    output logic cpuReady,
    output logic [31:0] cpuRData,
    // Memory bus side
    output logic busValid,
    output logic busWrite,
    output logic [31:0] busAddr,
    output logic [31:0] busWData,
    input logic busReady,
    input logic [31:0] busRData,
    maintIf.ctrl maint,
    wayIf.ctrl ways
);

    dcachePkg::cacheStateT state;
    dcachePkg::cacheStateT nextState;
    logic [dcachePkg::offsetBits-1:0] counter;
    logic [dcachePkg::setBits-1:0] sweepSet;
    // Second way of the current set
    logic sweepStep;
    // Read half of an uncached read-merge-write done
    logic rmwDone;
    logic [31:0] rdataQ;
    logic stepDone;
    logic isClean;

    // Request address fields
    logic [dcachePkg::tagBits-1:0] reqTag;
    logic [dcachePkg::setBits-1:0] reqSet;
    logic [dcachePkg::offsetBits-1:0] reqWord;

    assign reqTag = cpuAddr[31 -: dcachePkg::tagBits];
    assign reqSet = cpuAddr[2 + dcachePkg::offsetBits +: dcachePkg::setBits];
    assign reqWord = cpuAddr[2 +: dcachePkg::offsetBits];
    assign isClean = (maint.maintOp == dcachePkg::MAINT_CLEAN);

    // Byte muxes, new lanes where the mask is set
    function automatic logic [31:0] mergeBytes(input logic [31:0] oldWord,
                                               input logic [31:0] newWord,
                                               input logic [3:0] mask);
        logic [31:0] merged;
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = mask[b] ? newWord[8*b +: 8] : oldWord[8*b +: 8];
        end
        return merged;
    endfunction

    // ------------------
    // Next state, outputs
    // ------------------

    always_comb begin
        nextState = state;
        stepDone = 1'b0;
        cpuReady = 1'b0;
        busValid = 1'b0;
        busWrite = 1'b0;
        busAddr = {reqTag, reqSet, counter, 2'b00};
        busWData = cpuWData;
        maint.maintReady = 1'b0;
        ways.setIdx = reqSet;
        ways.wordIdx = reqWord;
        ways.wayWe = 2'b00;
        ways.tagWe = 1'b0;
        ways.newTag = reqTag;
        ways.newValid = 1'b1;
        ways.newDirty = 1'b0;
        ways.wData = cpuWData;
        ways.byteMask = 4'h0;
        ways.touch = 1'b0;
        case (state)
            dcachePkg::IDLE: begin
                // Processor first, sweeps only when it is quiet
                if (cpuValid) begin
                    nextState = dcachePkg::LOOKUP;
                end else if (maint.maintValid) begin
                    nextState = dcachePkg::SWEEP;
                end
            end
            dcachePkg::LOOKUP: begin
                if (!maint.cacheEnable) begin
                    nextState = dcachePkg::UNCACHED;
                end else if (ways.hit) begin
                    // Touch hit way, merge write bytes and mark dirty
                    ways.wayWe = {ways.hitWay, ~ways.hitWay};
                    ways.touch = 1'b1;
                    if (cpuWrite) begin
                        ways.byteMask = cpuByteMask;
                        ways.tagWe = 1'b1;
                        ways.newDirty = 1'b1;
                    end
                    nextState = dcachePkg::DONE;
                end else if (ways.victimValid && ways.victimDirty) begin
                    nextState = dcachePkg::WBACK;
                end else begin
                    nextState = dcachePkg::FILL;
                end
            end
            dcachePkg::WBACK: begin
                // LRU way stays put until the fill touches it
                ways.wordIdx = counter;
                busValid = 1'b1;
                busWrite = 1'b1;
                busAddr = {ways.victimTag, reqSet, counter, 2'b00};
                busWData = ways.rData[ways.lruWay];
                if (busReady && (&counter)) begin
                    nextState = dcachePkg::FILL;
                end
            end
            dcachePkg::FILL: begin
                ways.wordIdx = counter;
                busValid = 1'b1;
                ways.wData = (cpuWrite && counter == reqWord) ?
                    mergeBytes(busRData, cpuWData, cpuByteMask) : busRData;
                if (busReady) begin
                    ways.wayWe = {ways.lruWay, ~ways.lruWay};
                    ways.byteMask = 4'hF;
                    // Last beat installs the tag
                    if (&counter) begin
                        ways.tagWe = 1'b1;
                        ways.newDirty = cpuWrite;
                        ways.touch = 1'b1;
                        nextState = dcachePkg::DONE;
                    end
                end
            end
            dcachePkg::UNCACHED: begin
                busValid = 1'b1;
                busAddr = {cpuAddr[31:2], 2'b00};
                if (cpuWrite && (rmwDone || cpuByteMask == 4'hF)) begin
                    busWrite = 1'b1;
                    busWData = rmwDone ? rdataQ : cpuWData;
                    if (busReady) begin
                        nextState = dcachePkg::DONE;
                    end
                end else if (busReady && !cpuWrite) begin
                    nextState = dcachePkg::DONE;
                end
            end
            dcachePkg::SWEEP: begin
                ways.setIdx = sweepSet;
                ways.wordIdx = counter;
                ways.newTag = ways.victimTag;
                ways.newValid = isClean && ways.victimValid;
                if (isClean && ways.victimValid && ways.victimDirty) begin
                    busValid = 1'b1;
                    busWrite = 1'b1;
                    busAddr = {ways.victimTag, sweepSet, counter, 2'b00};
                    busWData = ways.rData[ways.lruWay];
                    stepDone = busReady && (&counter);
                end else begin
                    stepDone = 1'b1;
                end
                // Clear the line bits, flip LRU to reach the other way
                if (stepDone) begin
                    ways.wayWe = {ways.lruWay, ~ways.lruWay};
                    ways.tagWe = 1'b1;
                    ways.touch = 1'b1;
                    if (sweepStep && (&sweepSet)) begin
                        maint.maintReady = 1'b1;
                        nextState = dcachePkg::IDLE;
                    end
                end
            end
            dcachePkg::DONE: begin
                cpuReady = 1'b1;
                nextState = dcachePkg::IDLE;
            end
            default: begin
                nextState = dcachePkg::IDLE;
            end
        endcase
    end

    // ------------------
    // Registers
    // ------------------

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= dcachePkg::IDLE;
            counter <= '0;
            sweepSet <= '0;
            sweepStep <= 1'b0;
            rmwDone <= 1'b0;
        end else begin
            state <= nextState;
            if (state == dcachePkg::IDLE) begin
                counter <= '0;
                sweepSet <= '0;
                sweepStep <= 1'b0;
                rmwDone <= 1'b0;
            end
            // Beat counter wraps to zero between write-back and fill
            if (busValid && busReady && state != dcachePkg::UNCACHED) begin
                counter <= counter + 1'b1;
            end
            if (stepDone) begin
                sweepStep <= ~sweepStep;
                if (sweepStep) begin
                    sweepSet <= sweepSet + 1'b1;
                end
            end
            if (state == dcachePkg::UNCACHED && busReady && !busWrite && cpuWrite) begin
                rmwDone <= 1'b1;
            end
        end
    end

    // Read data for the processor
    always_ff @(posedge clk) begin
        if (state == dcachePkg::LOOKUP) begin
            rdataQ <= ways.rData[ways.hitWay];
        end else if (state == dcachePkg::FILL && busReady && counter == reqWord) begin
            rdataQ <= ways.wData;
        end else if (state == dcachePkg::UNCACHED && busReady && !busWrite) begin
            rdataQ <= cpuWrite ? mergeBytes(busRData, cpuWData, cpuByteMask) : busRData;
        end
    end

    assign cpuRData = rdataQ;

    // Bus request held until accepted
    busHoldA: assert property (@(posedge clk) disable iff (!rstN)
        busValid && !busReady |=> busValid && $stable(busWrite) && $stable(busAddr)
            && $stable(busWData));

    // One-cycle completion pulse
    cpuPulseA: assert property (@(posedge clk) disable iff (!rstN)
        cpuReady |=> !cpuReady);

endmodule

//--- dcacheIfs.sv
// ------------------
// Cache interfaces
// ------------------

// Config block to controller
interface maintIf;
    logic maintValid;
    dcachePkg::maintOpT maintOp;
    // Level, not a command
    logic cacheEnable;
    // Pulses when the sweep over all sets ends
    logic maintReady;

    modport cfg (output maintValid, maintOp, cacheEnable, input maintReady);
    modport ctrl (input maintValid, maintOp, cacheEnable, output maintReady);
endinterface

// Controller to way arrays
interface wayIf;
    logic [dcachePkg::setBits-1:0] setIdx;
    logic [dcachePkg::offsetBits-1:0] wordIdx;
    // One-hot way select for data, meta and touch
    logic [1:0] wayWe;
    logic tagWe;
    // Also the compare tag for hit detection
    logic [dcachePkg::tagBits-1:0] newTag;
    logic newValid;
    logic newDirty;
    logic [31:0] wData;
    logic [3:0] byteMask;
    logic touch;
    // Combinational lookup results
    logic hit;
    logic hitWay;
    logic lruWay;
    logic [dcachePkg::tagBits-1:0] victimTag;
    logic victimDirty;
    logic victimValid;
    logic [31:0] rData [2];

    modport ctrl (
        output setIdx, wordIdx, wayWe, tagWe, newTag, newValid, newDirty, wData,
        output byteMask, touch,
        input hit, hitWay, lruWay, victimTag, victimDirty, victimValid, rData
    );
    modport ways (
        input setIdx, wordIdx, wayWe, tagWe, newTag, newValid, newDirty, wData,
        input byteMask, touch,
        output hit, hitWay, lruWay, victimTag, victimDirty, victimValid, rData
    );
endinterface

//--- dcachePkg.sv
// ------------------
// Data cache package
// ------------------
package dcachePkg;

    // ------------------
    // Geometry
    // ------------------

    // Sets per way
    localparam int numSets = 8;
    // Words per block
    localparam int blockWords = 4;
    // Set index width
    localparam int setBits = 3;
    // Word offset width
    localparam int offsetBits = 2;
    // Address minus byte offset, word offset and set index
    localparam int tagBits = 32 - 2 - offsetBits - setBits;

    // ------------------
    // Encodings
    // ------------------

    // Controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WBACK,
        FILL,
        UNCACHED,
        SWEEP,
        DONE
    } cacheStateT;

    // Opcodes on the configuration port
    typedef enum logic [1:0] {
        CFG_ENABLE,
        CFG_DISABLE,
        CFG_INVALIDATE,
        CFG_CLEAN
    } cfgOpT;

    // Sweep commands to the controller
    typedef enum logic {
        MAINT_INVALIDATE,
        MAINT_CLEAN
    } maintOpT;

endpackage

//--- dcacheTop.sv
// ------------------
// Data cache top
// ------------------
module dcacheTop (
    input logic clk,
    input logic rstN,
    // Processor port
    input logic cpuValid,
    input logic cpuWrite,
    input logic [31:0] cpuAddr,
    input logic [31:0] cpuWData,
    input logic [3:0] cpuByteMask,
    output logic cpuReady,
    output logic [31:0] cpuRData,
    // Memory bus port
    output logic busValid,
    output logic busWrite,
    output logic [31:0] busAddr,
    output logic [31:0] busWData,
    input logic busReady,
    input logic [31:0] busRData,
    // Configuration port
    input logic cfgValid,
    input dcachePkg::cfgOpT cfgOp,
    output logic cfgReady
);

    maintIf maintBus ();
    wayIf wayBus ();

    // Enable register and maintenance requests
    dcacheConfig i_dcacheConfig (
        .clk(clk),
        .rstN(rstN),
        .cfgValid(cfgValid),
        .cfgOp(cfgOp),
        .cfgReady(cfgReady),
        .maint(maintBus)
    );

    dcacheController i_dcacheController (
        .clk(clk),
        .rstN(rstN),
        .cpuValid(cpuValid),
        .cpuWrite(cpuWrite),
        .cpuAddr(cpuAddr),
        .cpuWData(cpuWData),
        .cpuByteMask(cpuByteMask),
        .cpuReady(cpuReady),
        .cpuRData(cpuRData),
        .busValid(busValid),
        .busWrite(busWrite),
        .busAddr(busAddr),
        .busWData(busWData),
        .busReady(busReady),
        .busRData(busRData),
        .maint(maintBus),
        .ways(wayBus)
    );

    // Tag, state, data and LRU storage
    dcacheWays i_dcacheWays (
        .clk(clk),
        .rstN(rstN),
        .ways(wayBus)
    );

endmodule

//--- dcacheWays.sv
// ------------------
// Two-way cache arrays
// ------------------
module dcacheWays (
    input logic clk,
    input logic rstN,
    wayIf.ways ways
);

    // ------------------
    // Storage
    // ------------------

    logic [dcachePkg::tagBits-1:0] tagMem [2][dcachePkg::numSets];
    logic [31:0] dataMem [2][dcachePkg::numSets][dcachePkg::blockWords];
    // Bit per set and way
    logic [1:0][dcachePkg::numSets-1:0] validQ;
    logic [1:0][dcachePkg::numSets-1:0] dirtyQ;
    // Way to evict next, per set
    logic [dcachePkg::numSets-1:0] lruQ;

    logic [1:0] match;
    logic victim;

    // Tags and data, no reset
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            // Byte lanes
            for (int b = 0; b < 4; b++) begin
                if (ways.wayWe[w] && ways.byteMask[b]) begin
                    dataMem[w][ways.setIdx][ways.wordIdx][8*b +: 8] <= ways.wData[8*b +: 8];
                end
            end
            if (ways.wayWe[w] && ways.tagWe) begin
                tagMem[w][ways.setIdx] <= ways.newTag;
            end
        end
    end

    // Line state bits and LRU
    always_ff @(posedge clk) begin
        if (!rstN) begin
            validQ <= '0;
            dirtyQ <= '0;
            lruQ <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (ways.wayWe[w] && ways.tagWe) begin
                    validQ[w][ways.setIdx] <= ways.newValid;
                    dirtyQ[w][ways.setIdx] <= ways.newDirty;
                end
            end
            // Touched way becomes MRU, so LRU points at the other one
            if (ways.touch) begin
                lruQ[ways.setIdx] <= ways.wayWe[0];
            end
        end
    end

    // ------------------
    // Lookup
    // ------------------

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            match[w] = validQ[w][ways.setIdx] && (tagMem[w][ways.setIdx] == ways.newTag);
        end
    end

    assign ways.hit = |match;
    // Both ways never hold the same valid tag
    assign ways.hitWay = match[1];

    assign victim = lruQ[ways.setIdx];
    assign ways.lruWay = victim;
    assign ways.victimTag = tagMem[victim][ways.setIdx];
    assign ways.victimValid = validQ[victim][ways.setIdx];
    assign ways.victimDirty = dirtyQ[victim][ways.setIdx];

    // Read both ways at the addressed word
    assign ways.rData[0] = dataMem[0][ways.setIdx][ways.wordIdx];
    assign ways.rData[1] = dataMem[1][ways.setIdx][ways.wordIdx];

endmodule

//--- list.f
dcachePkg.sv
dcacheIfs.sv
dcacheConfig.sv
dcacheWays.sv
dcacheController.sv
dcacheTop.sv
tbDcache.sv

//--- tbDcache.sv
// ------------------
// Data cache testbench
// ------------------
module tbDcache;

    // Operation counts per phase
    localparam int numUncached = 50;
    localparam int numCached = 400;
    localparam int numRepeat = 30;
    localparam int numReload = 8;
    localparam int numCfg = 3;
    localparam int cyclesPerOp = 40;
    localparam int cycleLimit =
        cyclesPerOp * (numUncached + numCached + 2 * numRepeat + numReload + numCfg);

    logic clk;
    logic rstN;
    logic cpuValid;
    logic cpuWrite;
    logic [31:0] cpuAddr;
    logic [31:0] cpuWData;
    logic [3:0] cpuByteMask;
    logic cpuReady;
    logic [31:0] cpuRData;
    logic busValid;
    logic busWrite;
    logic [31:0] busAddr;
    logic [31:0] busWData;
    logic busReady;
    logic [31:0] busRData;
    logic cfgValid;
    dcachePkg::cfgOpT cfgOp;
    logic cfgReady;

    // Backing memory and expected processor view, one word each
    logic [31:0] mem [128];
    logic [31:0] model [128];

    integer seed = 80827;
    int cycleCount = 0;
    int busReads = 0;
    int busWrites = 0;
    logic [31:0] lastBusAddr;
    // Responder state
    logic pending;
    logic [1:0] waitCnt;

    dcacheTop i_dcacheTop (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Hard stop for a stuck handshake
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            $display("Simulation failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("ERR %0t: %s, got %h, expected %h", $time, msg, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Initial memory contents, unique per word
    function automatic logic [31:0] fillWord(input logic [7:0] idx);
        return {idx, ~idx, idx ^ 8'h5A, idx + 8'h11};
    endfunction

    // Byte lanes of the write replace the old word
    function automatic logic [31:0] applyMask(input logic [31:0] oldWord,
                                              input logic [31:0] newWord,
                                              input logic [3:0] mask);
        logic [31:0] laneBits;
        laneBits = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
        return (oldWord & ~laneBits) | (newWord & laneBits);
    endfunction

    // --------------------
    // Bus responder
    // --------------------

    always @(posedge clk) begin
        logic [31:0] rnd;
        if (!rstN) begin
            busReady <= 1'b0;
            pending = 1'b0;
        end else if (busReady) begin
            // Word moved in the cycle that just ended
            check({9'd0, busAddr[31:9]}, 32'd0, "bus address outside memory");
            if (busWrite) begin
                mem[busAddr[8:2]] = busWData;
                busWrites++;
            end else begin
                busReads++;
            end
            lastBusAddr = busAddr;
            busReady <= 1'b0;
            pending = 1'b0;
        end else if (busValid) begin
            // New request, pick a stall of 0 to 3 cycles
            if (!pending) begin
                rnd = $random(seed);
                waitCnt = rnd[1:0];
                pending = 1'b1;
            end
            if (waitCnt == 2'd0) begin
                busReady <= 1'b1;
                busRData <= mem[busAddr[8:2]];
            end else begin
                waitCnt--;
            end
        end
    end

    // --------------------
    // Stimulus tasks
    // --------------------

    // One processor access, latency counts cycles from cpuValid to cpuReady
    task automatic access(input logic write, input logic [6:0] idx, input logic [31:0] data,
                          input logic [3:0] mask, output int latency);
        @(posedge clk);
        cpuValid <= 1'b1;
        cpuWrite <= write;
        cpuAddr <= {23'd0, idx, 2'b00};
        cpuWData <= data;
        cpuByteMask <= mask;
        latency = 0;
        @(posedge clk);
        while (!cpuReady) begin
            latency++;
            @(posedge clk);
        end
        cpuValid <= 1'b0;
        if (write) begin
            model[idx] = applyMask(model[idx], data, mask);
        end else begin
            check(cpuRData, model[idx], "read data");
        end
    endtask

    task automatic configure(input dcachePkg::cfgOpT op);
        @(posedge clk);
        cfgValid <= 1'b1;
        cfgOp <= op;
        @(posedge clk);
        while (!cfgReady) begin
            @(posedge clk);
        end
        cfgValid <= 1'b0;
    endtask

    // Random access, about half with a full byte mask
    task automatic pickOp(output logic write, output logic [6:0] idx,
                          output logic [31:0] data, output logic [3:0] mask);
        logic [31:0] rnd;
        rnd = $random(seed);
        write = rnd[7];
        idx = rnd[6:0];
        mask = rnd[12] ? 4'hF : rnd[11:8];
        data = $random(seed);
    endtask

    // --------------------
    // Test sequence
    // --------------------

    initial begin
        logic [31:0] rnd;
        logic [31:0] wdata;
        logic [6:0] idx;
        logic [6:0] lastIdx;
        logic [3:0] mask;
        logic write;
        int readsBefore;
        int writesBefore;
        int latency;
        for (int i = 0; i < 128; i++) begin
            mem[i] = fillWord(i[7:0]);
            model[i] = fillWord(i[7:0]);
        end
        lastIdx = 7'd0;
        rstN = 1'b0;
        cpuValid = 1'b0;
        cpuWrite = 1'b0;
        cpuAddr = 32'd0;
        cpuWData = 32'd0;
        cpuByteMask = 4'h0;
        busReady = 1'b0;
        busRData = 32'd0;
        cfgValid = 1'b0;
        cfgOp = dcachePkg::CFG_ENABLE;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;

        // Disabled after reset, every access goes to the bus
        for (int i = 0; i < numUncached; i++) begin
            pickOp(write, idx, wdata, mask);
            readsBefore = busReads;
            writesBefore = busWrites;
            access(write, idx, wdata, mask, latency);
            check(busReads - readsBefore, (!write || mask != 4'hF) ? 32'd1 : 32'd0,
                  "uncached bus reads");
            check(busWrites - writesBefore, write ? 32'd1 : 32'd0, "uncached bus writes");
            check(lastBusAddr, {23'd0, idx, 2'b00}, "uncached bus address");
            if (write) begin
                check(mem[idx], model[idx], "uncached memory word");
            end
        end

        // Fills, evictions and write-backs
        configure(dcachePkg::CFG_ENABLE);
        for (int i = 0; i < numCached; i++) begin
            pickOp(write, idx, wdata, mask);
            access(write, idx, wdata, mask, latency);
        end

        // Second read of a word must hit
        for (int i = 0; i < numRepeat; i++) begin
            rnd = $random(seed);
            idx = rnd[6:0];
            access(1'b0, idx, 32'd0, 4'h0, latency);
            readsBefore = busReads;
            writesBefore = busWrites;
            access(1'b0, idx, 32'd0, 4'h0, latency);
            check((busReads - readsBefore) + (busWrites - writesBefore), 32'd0,
                  "bus traffic on repeated read");
            check(latency, 32'd2, "hit latency");
            lastIdx = idx;
        end

        // All dirty data back in memory
        configure(dcachePkg::CFG_CLEAN);
        for (int i = 0; i < 128; i++) begin
            check(mem[i], model[i], "memory word after clean");
        end

        // Each set misses again, lines are clean so no write-back
        configure(dcachePkg::CFG_INVALIDATE);
        for (int s = 0; s < numReload; s++) begin
            idx = {lastIdx[6:5], s[2:0], lastIdx[1:0]};
            readsBefore = busReads;
            writesBefore = busWrites;
            access(1'b0, idx, 32'd0, 4'h0, latency);
            check(busReads - readsBefore, dcachePkg::blockWords, "fill reads after invalidate");
            check(busWrites - writesBefore, 32'd0, "write-backs after invalidate");
        end

        $display("Simulation passed");
        $finish;
    end

endmodule
